// File: files.f
hw/fastica_pkg.sv
hw/lane_if.sv
hw/fastica_controller.sv
hw/sample_mem.sv
hw/ica_lane.sv
hw/weight_combine.sv
hw/fastica_top.sv
testbench/tb_fastica.sv

// File: hw/fastica_controller.sv
`default_nettype none

module fastica_controller
    import fastica_pkg::*;
#(
    parameter int max_iter = 32
) (
    input  logic       clk_fastica,
    input  logic       go_fastica,
    input  logic       symm_busy,
    input  logic       fast_busy,
    input  logic       is_converge,
    output logic       fastica_busy,
    output logic       go_symm,
    output logic       en_norm,
    output logic       go_fast,
    output logic       en_error,
    output logic       en_mul1,
    output logic       en_mem1,
    output logic       converged,
    output logic [7:0] iter_count
);

    fastica_state_e state;
    logic [6:0]     clk_cnt;

    // enables are a pure decode of the state
    always_comb begin
        go_symm      = 1'b0;
        en_norm      = 1'b0;
        go_fast      = 1'b0;
        en_error     = 1'b0;
        en_mul1      = 1'b0;
        en_mem1      = 1'b0;
        fastica_busy = 1'b1;
        case (state)
            init_st, done_st: fastica_busy = 1'b0;
            make_orth_st: go_symm = 1'b1;
            norm_div_st: en_norm = 1'b1;
            fast_ica_st: go_fast = 1'b1;
            error_delay_st, error_calc_st: en_error = 1'b1;
            mul1_st: en_mul1 = 1'b1;
            mem1_st: begin
                en_mul1 = 1'b1;
                en_mem1 = 1'b1;
            end
            default: fastica_busy = 1'b1;
        endcase
    end

    // clk_cnt is nonzero on entry to make_orth_st and fast_ica_st,
    // so the first cycle waits for the busy flag to come up
    always_ff @(posedge clk_fastica or negedge go_fastica) begin
        if (!go_fastica) begin
            state      <= init_st;
            iter_count <= 8'd0;
            converged  <= 1'b0;
        end else begin
            case (state)
                init_st: state <= delay_st;
                delay_st: state <= orth_delay_st;
                orth_delay_st: begin
                    if (clk_cnt == 7'd4) begin
                        state <= make_orth_st;
                    end
                end
                make_orth_st: begin
                    if (!symm_busy && clk_cnt == 7'd0) begin
                        state <= norm_div_st;
                    end
                end
                norm_div_st: state <= fast_ica_st;
                fast_ica_st: begin
                    if (!fast_busy && clk_cnt == 7'd0) begin
                        state <= error_delay_st;
                    end
                end
                error_delay_st: state <= error_calc_st;
                error_calc_st: begin
                    // fixed window before is_converge is trusted
                    if (clk_cnt == 7'd5) begin
                        iter_count <= iter_count + 8'd1;
                        if (is_converge || iter_count + 8'd1 >= max_iter) begin
                            converged <= is_converge;
                            state     <= mul1_st;
                        end else begin
                            state <= make_orth_st;
                        end
                    end
                end
                mul1_st: state <= mem1_st;
                mem1_st: begin
                    if (clk_cnt == 7'd127) begin
                        state <= done_st;
                    end
                end
                done_st: state <= done_st;
                default: state <= init_st;
            endcase
        end
    end

    always_ff @(posedge clk_fastica or negedge go_fastica) begin
        if (!go_fastica) begin
            clk_cnt <= 7'd0;
        end else begin
            case (state)
                mem1_st, orth_delay_st, norm_div_st, error_delay_st, error_calc_st: begin
                    clk_cnt <= clk_cnt + 7'd1;
                end
                default: clk_cnt <= 7'd0;
            endcase
        end
    end

    // combiner and lanes must never be started together
    assert property (@(posedge clk_fastica) disable iff (!go_fastica)
        !(go_symm && go_fast));

    assert property (@(posedge clk_fastica) disable iff (!go_fastica)
        state == done_st |=> state == done_st);

endmodule

`default_nettype wire

// File: hw/fastica_pkg.sv
`default_nettype none

package fastica_pkg;

    // signed Q2.13 samples and weights
    localparam int data_width       = 16;
    localparam int frac_bits        = 13;
    localparam int acc_width        = 48;
    localparam int num_samples_log2 = 7;
    localparam int num_samples      = 1 << num_samples_log2;

    typedef logic signed [data_width-1:0] sample_t;
    typedef sample_t wvec_t [2];

    localparam sample_t sample_max = sample_t'((1 << (data_width - 1)) - 1);
    localparam sample_t sample_min = -sample_max - sample_t'(1);

    typedef enum logic [3:0] {
        init_st, delay_st, orth_delay_st, make_orth_st, norm_div_st, fast_ica_st,
        error_delay_st, error_calc_st, mul1_st, mem1_st, done_st
    } fastica_state_e;

    // about (0.6, 0.8) and its rotation by 90 degrees
    localparam wvec_t w0_init = '{sample_t'(4915), sample_t'(6554)};
    localparam wvec_t w1_init = '{sample_t'(-6554), sample_t'(4915)};

    // clamp a wide result into a sample word
    function automatic sample_t sat(input longint v);
        if (v > sample_max) begin
            return sample_max;
        end else if (v < sample_min) begin
            return sample_min;
        end
        return sample_t'(v);
    endfunction

endpackage

`default_nettype wire

// File: hw/fastica_top.sv
`default_nettype none

module fastica_top
    import fastica_pkg::*;
#(
    parameter int max_iter = 32,
    parameter int tol      = 8
) (
    input  logic                        clk_fastica,
    input  logic                        go_fastica,
    input  logic                        load_en,
    input  logic [num_samples_log2-1:0] load_addr,
    input  sample_t                     load_x0,
    input  sample_t                     load_x1,
    output logic                        fastica_busy,
    output logic                        converged,
    output logic [7:0]                  iter_count,
    output logic                        out_valid,
    output logic [num_samples_log2-1:0] out_addr,
    output sample_t                     out_y0,
    output sample_t                     out_y1
);

    logic                        go_symm, en_norm, go_fast, en_error, en_mul1, en_mem1;
    logic                        symm_busy, is_converge, fast_busy;
    sample_t                     s_x0, s_x1;
    logic                        s_valid, s_last;
    logic [num_samples_log2-1:0] s_addr;

    lane_if lane_a_if ();
    lane_if lane_b_if ();

    // update pass ends when both lanes are done
    assign fast_busy = lane_a_if.busy | lane_b_if.busy;

    fastica_controller #(
        .max_iter(max_iter)
    ) controller (
        .clk_fastica (clk_fastica),
        .go_fastica  (go_fastica),
        .symm_busy   (symm_busy),
        .fast_busy   (fast_busy),
        .is_converge (is_converge),
        .fastica_busy(fastica_busy),
        .go_symm     (go_symm),
        .en_norm     (en_norm),
        .go_fast     (go_fast),
        .en_error    (en_error),
        .en_mul1     (en_mul1),
        .en_mem1     (en_mem1),
        .converged   (converged),
        .iter_count  (iter_count)
    );

    sample_mem mem (
        .clk_fastica(clk_fastica),
        .go_fastica (go_fastica),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_x0    (load_x0),
        .load_x1    (load_x1),
        .go_fast    (go_fast),
        .en_mul1    (en_mul1),
        .s_x0       (s_x0),
        .s_x1       (s_x1),
        .s_valid    (s_valid),
        .s_last     (s_last),
        .stream_busy(),
        .s_addr     (s_addr)
    );

    ica_lane #(
        .acc_width(acc_width)
    ) lane_a (
        .clk_fastica(clk_fastica),
        .go_fastica (go_fastica),
        .start      (go_fast),
        .s_x0       (s_x0),
        .s_x1       (s_x1),
        .s_valid    (s_valid),
        .s_last     (s_last),
        .lane       (lane_a_if.lane)
    );

    ica_lane #(
        .acc_width(acc_width)
    ) lane_b (
        .clk_fastica(clk_fastica),
        .go_fastica (go_fastica),
        .start      (go_fast),
        .s_x0       (s_x0),
        .s_x1       (s_x1),
        .s_valid    (s_valid),
        .s_last     (s_last),
        .lane       (lane_b_if.lane)
    );

    weight_combine #(
        .tol(tol)
    ) combiner (
        .clk_fastica(clk_fastica),
        .go_fastica (go_fastica),
        .go_symm    (go_symm),
        .en_norm    (en_norm),
        .en_error   (en_error),
        .en_mem1    (en_mem1),
        .s_x0       (s_x0),
        .s_x1       (s_x1),
        .s_valid    (s_valid),
        .s_addr     (s_addr),
        .lane_a     (lane_a_if.comb),
        .lane_b     (lane_b_if.comb),
        .symm_busy  (symm_busy),
        .is_converge(is_converge),
        .out_valid  (out_valid),
        .out_addr   (out_addr),
        .out_y0     (out_y0),
        .out_y1     (out_y1)
    );

endmodule

`default_nettype wire

// File: hw/ica_lane.sv
`default_nettype none

module ica_lane
    import fastica_pkg::*;
#(
    parameter int acc_width = fastica_pkg::acc_width
) (
    input  logic    clk_fastica,
    input  logic    go_fastica,
    input  logic    start,
    input  sample_t s_x0,
    input  sample_t s_x1,
    input  logic    s_valid,
    input  logic    s_last,
    lane_if.lane    lane
);

    // width of the projection after scaling
    localparam int pw = 2 * data_width - frac_bits + 1;

    logic                         start_d;
    logic                         go;
    logic                         v1, v2, l1, l2;
    logic signed [2*data_width:0] dot;
    logic signed [pw-1:0]         p;
    logic signed [2*pw-1:0]       sq;
    logic signed [3*pw-1:0]       cube;
    logic signed [acc_width-1:0]  p3;
    logic signed [acc_width-1:0]  acc0, acc1, acc0_nx, acc1_nx;
    sample_t                      x0_d1, x1_d1, x0_d2, x1_d2;

    assign go      = start && !start_d;
    assign dot     = s_x0 * lane.w_cur[0] + s_x1 * lane.w_cur[1];
    assign sq      = (p * p) >>> frac_bits;
    assign cube    = (sq * p) >>> frac_bits;
    assign acc0_nx = acc0 + x0_d2 * p3;
    assign acc1_nx = acc1 + x1_d2 * p3;

    // valid and last travel with the data
    always_ff @(posedge clk_fastica or negedge go_fastica) begin
        if (!go_fastica) begin
            start_d   <= 1'b0;
            lane.busy <= 1'b0;
            v1        <= 1'b0;
            v2        <= 1'b0;
            l1        <= 1'b0;
            l2        <= 1'b0;
        end else begin
            start_d <= start;
            v1      <= lane.busy && s_valid;
            l1      <= lane.busy && s_valid && s_last;
            v2      <= v1;
            l2      <= l1;
            if (go) begin
                lane.busy <= 1'b1;
            end else if (v2 && l2) begin
                lane.busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_fastica) begin
        // stage one, projection
        p     <= pw'(dot >>> frac_bits);
        x0_d1 <= s_x0;
        x1_d1 <= s_x1;
        // stage two, cube
        p3    <= acc_width'(cube);
        x0_d2 <= x0_d1;
        x1_d2 <= x1_d1;
        // stage three, accumulate x * p^3
        if (go) begin
            acc0 <= '0;
            acc1 <= '0;
        end else if (v2) begin
            acc0 <= acc0_nx;
            acc1 <= acc1_nx;
        end
        // mean over the samples minus 3w
        if (v2 && l2) begin
            lane.w_new[0] <= sat((acc0_nx >>> (frac_bits + num_samples_log2))
                                 - 3 * lane.w_cur[0]);
            lane.w_new[1] <= sat((acc1_nx >>> (frac_bits + num_samples_log2))
                                 - 3 * lane.w_cur[1]);
        end
    end

endmodule

`default_nettype wire

// File: hw/lane_if.sv
`default_nettype none

interface lane_if
    import fastica_pkg::*;
();

    // weight vector handed to the lane
    wvec_t w_cur;
    // result of one fixed-point update
    wvec_t w_new;
    logic  busy;

    modport lane (
        input  w_cur,
        output w_new,
        output busy
    );

    modport comb (
        output w_cur,
        input  w_new,
        input  busy
    );

endinterface

`default_nettype wire

// File: hw/sample_mem.sv
`default_nettype none

module sample_mem
    import fastica_pkg::*;
(
    input  logic                        clk_fastica,
    input  logic                        go_fastica,
    input  logic                        load_en,
    input  logic [num_samples_log2-1:0] load_addr,
    input  sample_t                     load_x0,
    input  sample_t                     load_x1,
    input  logic                        go_fast,
    input  logic                        en_mul1,
    output sample_t                     s_x0,
    output sample_t                     s_x1,
    output logic                        s_valid,
    output logic                        s_last,
    output logic                        stream_busy,
    output logic [num_samples_log2-1:0] s_addr
);

    sample_t                     mem_x0 [num_samples];
    sample_t                     mem_x1 [num_samples];
    logic                        go_fast_d;
    logic                        en_mul1_d;
    logic                        start;
    logic [num_samples_log2-1:0] rd_addr;

    // one pulse per update pass or output pass
    assign start = (go_fast && !go_fast_d) || (en_mul1 && !en_mul1_d);

    // loading only while the engine is held in reset
    always_ff @(posedge clk_fastica) begin
        if (load_en && !go_fastica) begin
            mem_x0[load_addr] <= load_x0;
            mem_x1[load_addr] <= load_x1;
        end
    end

    always_ff @(posedge clk_fastica or negedge go_fastica) begin
        if (!go_fastica) begin
            go_fast_d   <= 1'b0;
            en_mul1_d   <= 1'b0;
            stream_busy <= 1'b0;
            rd_addr     <= '0;
        end else begin
            go_fast_d <= go_fast;
            en_mul1_d <= en_mul1;
            if (start) begin
                stream_busy <= 1'b1;
                rd_addr     <= '0;
            end else if (stream_busy) begin
                rd_addr <= rd_addr + 1'b1;
                if (s_last) begin
                    stream_busy <= 1'b0;
                end
            end
        end
    end

    assign s_valid = stream_busy;
    assign s_last  = stream_busy && rd_addr == num_samples_log2'(num_samples - 1);
    assign s_addr  = rd_addr;
    assign s_x0    = mem_x0[rd_addr];
    assign s_x1    = mem_x1[rd_addr];

    assert property (@(posedge clk_fastica) go_fastica |-> !load_en);

endmodule

`default_nettype wire

// File: hw/weight_combine.sv
`default_nettype none

module weight_combine
    import fastica_pkg::*;
#(
    parameter int tol = 8
) (
    input  logic                        clk_fastica,
    input  logic                        go_fastica,
    input  logic                        go_symm,
    input  logic                        en_norm,
    input  logic                        en_error,
    input  logic                        en_mem1,
    input  sample_t                     s_x0,
    input  sample_t                     s_x1,
    input  logic                        s_valid,
    input  logic [num_samples_log2-1:0] s_addr,
    lane_if.comb                        lane_a,
    lane_if.comb                        lane_b,
    output logic                        symm_busy,
    output logic                        is_converge,
    output logic                        out_valid,
    output logic [num_samples_log2-1:0] out_addr,
    output sample_t                     out_y0,
    output sample_t                     out_y1
);

    wvec_t                                  w0, w1, wn0, wn1;
    logic                                   go_symm_d;
    logic [1:0]                             symm_step;
    logic [1:0]                             err_cnt;
    logic signed [2*data_width:0]           dot_r, y0_full, y1_full;
    logic signed [3*data_width-frac_bits:0] prod_r [2];

    // scale by a power of two so the larger magnitude has its msb at frac_bits-1
    function automatic wvec_t renorm(input wvec_t v);
        logic [data_width:0] m0, m1, m;
        int                  msb;
        wvec_t               r;
        m0  = (v[0] < 0) ? -v[0] : v[0];
        m1  = (v[1] < 0) ? -v[1] : v[1];
        m   = (m0 > m1) ? m0 : m1;
        msb = frac_bits - 1;
        for (int i = 0; i <= data_width; i++) begin
            if (m[i]) begin
                msb = i;
            end
        end
        for (int k = 0; k < 2; k++) begin
            if (msb >= frac_bits - 1) begin
                r[k] = v[k] >>> (msb - frac_bits + 1);
            end else begin
                r[k] = v[k] <<< (frac_bits - 1 - msb);
            end
        end
        return r;
    endfunction

    function automatic logic near(input sample_t a, input sample_t b, input logic neg);
        logic signed [data_width+1:0] d;
        d = neg ? a + b : a - b;
        return (d <= tol) && (d >= -tol);
    endfunction

    // a flipped sign still counts as the same direction
    function automatic logic same_dir(input wvec_t a, input wvec_t b);
        return (near(a[0], b[0], 1'b0) && near(a[1], b[1], 1'b0)) ||
               (near(a[0], b[0], 1'b1) && near(a[1], b[1], 1'b1));
    endfunction

    assign lane_a.w_cur = w0;
    assign lane_b.w_cur = w1;
    assign y0_full      = w0[0] * s_x0 + w0[1] * s_x1;
    assign y1_full      = w1[0] * s_x0 + w1[1] * s_x1;

    always_ff @(posedge clk_fastica or negedge go_fastica) begin
        if (!go_fastica) begin
            w0          <= w0_init;
            w1          <= w1_init;
            go_symm_d   <= 1'b0;
            symm_busy   <= 1'b0;
            symm_step   <= 2'd0;
            err_cnt     <= 2'd0;
            is_converge <= 1'b0;
            out_valid   <= 1'b0;
        end else begin
            go_symm_d <= go_symm;
            out_valid <= en_mem1 && s_valid;
            // deflation of w1 against w0 in three steps
            if (go_symm && !go_symm_d) begin
                symm_busy <= 1'b1;
                symm_step <= 2'd0;
            end else if (symm_busy) begin
                symm_step <= symm_step + 2'd1;
                if (symm_step == 2'd2) begin
                    symm_busy <= 1'b0;
                    for (int k = 0; k < 2; k++) begin
                        w1[k] <= sat(w1[k] - (prod_r[k] >>> frac_bits));
                    end
                end
            end
            if (en_norm) begin
                w0 <= renorm(w0);
                w1 <= renorm(w1);
            end
            if (!en_error) begin
                err_cnt <= 2'd0;
            end else if (err_cnt != 2'd2) begin
                err_cnt <= err_cnt + 2'd1;
            end
            // second error cycle: compare, then keep the new vectors
            if (en_error && err_cnt == 2'd1) begin
                is_converge <= same_dir(wn0, w0) && same_dir(wn1, w1);
                w0          <= wn0;
                w1          <= wn1;
            end
        end
    end

    always_ff @(posedge clk_fastica) begin
        if (symm_busy && symm_step == 2'd0) begin
            dot_r <= w0[0] * w1[0] + w0[1] * w1[1];
        end
        if (symm_busy && symm_step == 2'd1) begin
            for (int k = 0; k < 2; k++) begin
                prod_r[k] <= (dot_r >>> frac_bits) * w0[k];
            end
        end
        if (en_error && err_cnt == 2'd0) begin
            wn0 <= renorm(lane_a.w_new);
            wn1 <= renorm(lane_b.w_new);
        end
        // unmixed output, one cycle behind the stream
        if (en_mem1 && s_valid) begin
            out_addr <= s_addr;
            out_y0   <= sat(y0_full >>> frac_bits);
            out_y1   <= sat(y1_full >>> frac_bits);
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_fastica.sv
`default_nettype none

module tb_fastica;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int max_iter_main  = 32;
    localparam int max_iter_short = 2;
    localparam int tol_value      = 8;
    localparam int samples        = 128;
    localparam int frac           = 13;
    localparam int samples_log2   = 7;
    // longest allowed run with margin, for every run that gets started
    localparam int cycles_per_test = 3 * (max_iter_main * 160 + 200);
    localparam int run_count       = 3;
    localparam int cycle_limit     = run_count * cycles_per_test;

    logic               clk_fastica = 1'b0;
    logic               go_fastica;
    logic               load_en;
    logic [6:0]         load_addr;
    logic signed [15:0] load_x0;
    logic signed [15:0] load_x1;

    logic               main_busy, main_conv, main_valid;
    logic [7:0]         main_iters;
    logic [6:0]         main_addr;
    logic signed [15:0] main_y0, main_y1;
    logic               lim_busy, lim_conv, lim_valid;
    logic [7:0]         lim_iters;
    logic [6:0]         lim_addr;
    logic signed [15:0] lim_y0, lim_y1;

    int          data_x0 [samples];
    int          data_x1 [samples];
    longint      exp_y0 [2][samples];
    longint      exp_y1 [2][samples];
    bit          exp_conv [2];
    int          exp_iters [2];
    int          out_count [2];
    bit          busy_prev [2];
    bit          run_done [2];
    int          cycle_count = 0;

    always #2 clk_fastica = ~clk_fastica;

    fastica_top #(
        .max_iter(max_iter_main),
        .tol     (tol_value)
    ) uut (
        .clk_fastica (clk_fastica),
        .go_fastica  (go_fastica),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_x0     (load_x0),
        .load_x1     (load_x1),
        .fastica_busy(main_busy),
        .converged   (main_conv),
        .iter_count  (main_iters),
        .out_valid   (main_valid),
        .out_addr    (main_addr),
        .out_y0      (main_y0),
        .out_y1      (main_y1)
    );

    // same data, but the iteration limit cuts the loop short
    fastica_top #(
        .max_iter(max_iter_short),
        .tol     (tol_value)
    ) uut_limit (
        .clk_fastica (clk_fastica),
        .go_fastica  (go_fastica),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_x0     (load_x0),
        .load_x1     (load_x1),
        .fastica_busy(lim_busy),
        .converged   (lim_conv),
        .iter_count  (lim_iters),
        .out_valid   (lim_valid),
        .out_addr    (lim_addr),
        .out_y0      (lim_y0),
        .out_y1      (lim_y1)
    );

    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_problem(input string what);
        $display("Error at time %0t: %s", $time, what);
        abort_run();
    endtask

    task automatic check_value(input string name, input logic signed [63:0] expected,
                               input logic signed [63:0] actual);
        if (expected !== actual) begin
            $display("Fail at time %0t: %s expected %0d, got %0d", $time, name, expected,
                     actual);
            abort_run();
        end
    endtask

    function automatic string dut_name(input int idx);
        return (idx == 0) ? "uut" : "uut_limit";
    endfunction

    function automatic longint clamp_sample(input longint v);
        if (v > 32767) begin
            return 32767;
        end else if (v < -32768) begin
            return -32768;
        end
        return v;
    endfunction

    // lane accumulators are 48 bits wide
    function automatic longint wrap48(input longint v);
        logic signed [47:0] t;
        t = v[47:0];
        return t;
    endfunction

    function automatic longint absval(input longint v);
        return (v < 0) ? -v : v;
    endfunction

    // power-of-two scaling, largest magnitude lands in 4096..8191
    task automatic scale_pair(inout longint a, inout longint b);
        longint m;
        int     msb;
        m   = (absval(a) > absval(b)) ? absval(a) : absval(b);
        msb = frac - 1;
        for (int i = 0; i <= 16; i++) begin
            if (m[i]) begin
                msb = i;
            end
        end
        if (msb >= frac - 1) begin
            a = a >>> (msb - frac + 1);
            b = b >>> (msb - frac + 1);
        end else begin
            a = a <<< (frac - 1 - msb);
            b = b <<< (frac - 1 - msb);
        end
    endtask

    function automatic bit vectors_match(input longint a0, input longint a1,
                                         input longint b0, input longint b1);
        bit direct;
        bit flipped;
        direct  = absval(a0 - b0) <= tol_value && absval(a1 - b1) <= tol_value;
        flipped = absval(a0 + b0) <= tol_value && absval(a1 + b1) <= tol_value;
        return direct || flipped;
    endfunction

    // one fixed-point update, mean of x * (w.x)^3 minus 3w
    task automatic update_vector(input longint wa, input longint wb,
                                 output longint na, output longint nb);
        longint acc0, acc1, p, sq, cube;
        acc0 = 0;
        acc1 = 0;
        for (int i = 0; i < samples; i++) begin
            p    = (data_x0[i] * wa + data_x1[i] * wb) >>> frac;
            sq   = (p * p) >>> frac;
            cube = (sq * p) >>> frac;
            acc0 = wrap48(acc0 + data_x0[i] * cube);
            acc1 = wrap48(acc1 + data_x1[i] * cube);
        end
        na = clamp_sample((acc0 >>> (frac + samples_log2)) - 3 * wa);
        nb = clamp_sample((acc1 >>> (frac + samples_log2)) - 3 * wb);
    endtask

    task automatic run_model(input int idx, input int limit);
        longint w [4];
        longint n [4];
        longint d;
        bit     conv;
        int     iters;
        w     = '{4915, 6554, -6554, 4915};
        conv  = 1'b0;
        iters = 0;
        do begin
            // deflate the second vector against the first
            d    = (w[0] * w[2] + w[1] * w[3]) >>> frac;
            w[2] = clamp_sample(w[2] - ((d * w[0]) >>> frac));
            w[3] = clamp_sample(w[3] - ((d * w[1]) >>> frac));
            scale_pair(w[0], w[1]);
            scale_pair(w[2], w[3]);
            update_vector(w[0], w[1], n[0], n[1]);
            update_vector(w[2], w[3], n[2], n[3]);
            scale_pair(n[0], n[1]);
            scale_pair(n[2], n[3]);
            conv  = vectors_match(n[0], n[1], w[0], w[1]) &&
                    vectors_match(n[2], n[3], w[2], w[3]);
            w     = n;
            iters = iters + 1;
        end while (!conv && iters < limit);
        for (int i = 0; i < samples; i++) begin
            exp_y0[idx][i] = clamp_sample((w[0] * data_x0[i] + w[1] * data_x1[i]) >>> frac);
            exp_y1[idx][i] = clamp_sample((w[2] * data_x0[i] + w[3] * data_x1[i]) >>> frac);
        end
        exp_conv[idx]  = conv;
        exp_iters[idx] = iters;
        $display("model for %s: %0d iterations, converged %0d", dut_name(idx), iters, conv);
    endtask

    task automatic compute_expected();
        run_model(0, max_iter_main);
        run_model(1, max_iter_short);
    endtask

    // a +-0.5 source and a uniform source, mixed by a random rotation
    task automatic make_data();
        real angle, c, s, src_a, src_b;
        angle = ($urandom % 6283) / 1000.0;
        c     = $cos(angle);
        s     = $sin(angle);
        for (int i = 0; i < samples; i++) begin
            src_a      = ($urandom % 2) ? 4096.0 : -4096.0;
            src_b      = real'(int'($urandom % 12001) - 6000);
            data_x0[i] = $rtoi(c * src_a - s * src_b);
            data_x1[i] = $rtoi(s * src_a + c * src_b);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_fastica);
        #1;
    endtask

    task automatic reset_and_load();
        go_fastica = 1'b0;
        load_en    = 1'b0;
        repeat (4) next_cycle();
        for (int i = 0; i < samples; i++) begin
            load_en   = 1'b1;
            load_addr = 7'(i);
            load_x0   = data_x0[i][15:0];
            load_x1   = data_x1[i][15:0];
            next_cycle();
        end
        load_en = 1'b0;
        next_cycle();
    endtask

    task automatic wait_for_done();
        while (!(run_done[0] && run_done[1])) begin
            next_cycle();
        end
    endtask

    task automatic check_run_end();
        // extra cycles so a stray output sample would be seen
        repeat (10) next_cycle();
        for (int idx = 0; idx < 2; idx++) begin
            check_value({dut_name(idx), ".converged"}, exp_conv[idx],
                        (idx == 0) ? main_conv : lim_conv);
            check_value({dut_name(idx), ".iter_count"}, exp_iters[idx],
                        (idx == 0) ? main_iters : lim_iters);
        end
    endtask

    task automatic watch_outputs(input int idx, input logic busy, input logic valid,
                                 input logic [6:0] addr, input logic signed [15:0] y0,
                                 input logic signed [15:0] y1, input logic conv);
        if (!go_fastica) begin
            check_value({dut_name(idx), ".fastica_busy"}, 0, busy);
            check_value({dut_name(idx), ".out_valid"}, 0, valid);
            check_value({dut_name(idx), ".converged"}, 0, conv);
            out_count[idx] = 0;
            busy_prev[idx] = 1'b0;
            run_done[idx]  = 1'b0;
        end else begin
            if (valid) begin
                if (out_count[idx] >= samples) begin
                    report_problem({dut_name(idx), " output stream was too long"});
                end else begin
                    check_value({dut_name(idx), ".out_addr"}, out_count[idx], addr);
                    check_value({dut_name(idx), ".out_y0"}, exp_y0[idx][out_count[idx]], y0);
                    check_value({dut_name(idx), ".out_y1"}, exp_y1[idx][out_count[idx]], y1);
                    out_count[idx] = out_count[idx] + 1;
                end
            end
            // busy may only drop together with the last output sample
            if (busy_prev[idx] && !busy) begin
                if (out_count[idx] != samples) begin
                    report_problem({dut_name(idx),
                                    " output stream was too short when fastica_busy fell"});
                end else begin
                    run_done[idx] = 1'b1;
                end
            end
            busy_prev[idx] = busy;
        end
    endtask

    always @(negedge clk_fastica) begin
        watch_outputs(0, main_busy, main_valid, main_addr, main_y0, main_y1, main_conv);
        watch_outputs(1, lim_busy, lim_valid, lim_addr, lim_y0, lim_y1, lim_conv);
    end

    always @(posedge clk_fastica) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            report_problem("timeout, the engine did not reach its done state");
        end
    end

    initial begin
        go_fastica = 1'b0;
        load_en    = 1'b0;
        load_addr  = '0;
        load_x0    = '0;
        load_x1    = '0;
        void'($urandom(44));
        next_cycle();

        // full run on fresh data
        make_data();
        compute_expected();
        reset_and_load();
        go_fastica = 1'b1;
        wait_for_done();
        check_run_end();

        // this run is cut off by reset partway through
        make_data();
        compute_expected();
        reset_and_load();
        go_fastica = 1'b1;
        repeat (400) next_cycle();

        // restart on new data after the mid-run reset
        make_data();
        compute_expected();
        reset_and_load();
        go_fastica = 1'b1;
        wait_for_done();
        check_run_end();

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire
